// ==== src/pmp_cfg_pkg.sv ====
package pmp_cfg_pkg;

  //////////////////////////////////////////////////
  // entry count and privilege codes
  //////////////////////////////////////////////////

  localparam int PMP_CNT   = 8;                 // entries implemented
  localparam int PMP_IDX_W = $clog2(PMP_CNT);   // width of an entry index

  localparam logic [1:0] PRV_U = 2'd0;
  localparam logic [1:0] PRV_S = 2'd1;
  localparam logic [1:0] PRV_M = 2'd3;

  //////////////////////////////////////////////////
  // pmpcfg byte layout
  //////////////////////////////////////////////////

  // A field encodings
  localparam logic [1:0] OFF   = 2'd0;          // entry disabled
  localparam logic [1:0] TOR   = 2'd1;          // top of range
  localparam logic [1:0] NA4   = 2'd2;          // naturally aligned 4 bytes
  localparam logic [1:0] NAPOT = 2'd3;          // naturally aligned power of two

  localparam int CFG_R    = 0;
  localparam int CFG_W    = 1;
  localparam int CFG_X    = 2;
  localparam int CFG_A_LO = 3;                  // A occupies bits 4:3
  localparam int CFG_L    = 7;

  // bits 6:5 are reserved and always read zero
  localparam logic [7:0] CFG_WMASK = 8'h9f;

  //////////////////////////////////////////////////
  // csr map
  //////////////////////////////////////////////////

  localparam logic [11:0] CSR_PMPCFG0  = 12'h3a0;
  localparam logic [11:0] CSR_PMPCFG1  = 12'h3a1;
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3b0;   // pmpaddr0..7 at 0x3b0..0x3b7

  // four cfg bytes per 32 bit pmpcfg register
  localparam int CFG_PER_CSR = 4;
  localparam int CFG_CSR_CNT = PMP_CNT / CFG_PER_CSR;

endpackage

// ==== src/mem_access_pkg.sv ====
package mem_access_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  localparam int XLEN = 32;     // csr data width
  localparam int PLEN = 34;     // pmpaddr holds bits 33:2 of this

  //////////////////////////////////////////////////
  // transfer sizes
  //////////////////////////////////////////////////

  localparam logic [2:0] BYTE  = 3'd0;
  localparam logic [2:0] HWORD = 3'd1;
  localparam logic [2:0] WORD  = 3'd2;
  localparam logic [2:0] DWORD = 3'd3;

  // byte count of one transfer
  function automatic logic [3:0] size2bytes(logic [2:0] size);
    case (size)
      BYTE:    return 4'd1;
      HWORD:   return 4'd2;
      WORD:    return 4'd4;
      DWORD:   return 4'd8;
      default: return 4'd1;     // undefined codes act as a single byte
    endcase
  endfunction

endpackage

// ==== src/pmp_csr_file.sv ====
module pmp_csr_file (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,

  // csr port from the core
  input  logic                                                 csr_we_i,
  input  logic [11:0]                                          csr_adr_i,
  input  logic [mem_access_pkg::XLEN-1:0]                      csr_wdata_i,
  output logic [mem_access_pkg::XLEN-1:0]                      csr_rdata_o,

  // state towards the checker
  output logic [pmp_cfg_pkg::PMP_CNT-1:0][7:0]                 cfg_o,
  output logic [pmp_cfg_pkg::PMP_CNT-1:0][mem_access_pkg::XLEN-1:0] addr_o
);

  import pmp_cfg_pkg::*;
  import mem_access_pkg::*;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  logic [PMP_CNT-1:0][7:0]      cfg_q;       // one byte per entry
  logic [PMP_CNT-1:0][XLEN-1:0] addr_q;      // address bits 33:2

  logic [PMP_CNT-1:0] cfg_lock;   // L bit per entry
  logic [PMP_CNT-1:0] tor_lock;   // locked and in TOR mode
  logic [PMP_CNT-1:0] addr_lock;  // pmpaddr write blocked

  // legalize one written cfg byte
  function automatic logic [7:0] legal_cfg(logic [7:0] wbyte);
    logic [7:0] b;
    b        = wbyte & CFG_WMASK;                  // drop reserved bits
    b[CFG_W] = wbyte[CFG_W] & wbyte[CFG_R];        // W without R is reserved
    return b;
  endfunction

  //////////////////////////////////////////////////
  // lock decode
  //////////////////////////////////////////////////

  always_comb begin
    for (int n = 0; n < PMP_CNT; n++) begin
      cfg_lock[n] = cfg_q[n][CFG_L];
      tor_lock[n] = cfg_q[n][CFG_L] & (cfg_q[n][CFG_A_LO +: 2] == TOR);
    end
  end

  // entry n is also frozen when entry n+1 is a locked TOR using it as base
  assign addr_lock = cfg_lock | {1'b0, tor_lock[PMP_CNT-1:1]};

  //////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
    end else if (csr_we_i) begin
      // pmpcfg words
      for (int k = 0; k < CFG_CSR_CNT; k++) begin
        if (csr_adr_i == CSR_PMPCFG0 + 12'(k)) begin
          for (int j = 0; j < CFG_PER_CSR; j++) begin
            if (!cfg_lock[k*CFG_PER_CSR + j]) begin
              cfg_q[k*CFG_PER_CSR + j] <= legal_cfg(csr_wdata_i[8*j +: 8]);
            end
          end
        end
      end

      // pmpaddr registers
      for (int n = 0; n < PMP_CNT; n++) begin
        if (csr_adr_i == CSR_PMPADDR0 + 12'(n) && !addr_lock[n]) begin
          addr_q[n] <= csr_wdata_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // readback
  //////////////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;                               // unknown csr reads zero
    for (int k = 0; k < CFG_CSR_CNT; k++) begin
      if (csr_adr_i == CSR_PMPCFG0 + 12'(k)) begin
        csr_rdata_o = cfg_q[k*CFG_PER_CSR + CFG_PER_CSR - 1 -: CFG_PER_CSR];
      end
    end
    for (int n = 0; n < PMP_CNT; n++) begin
      if (csr_adr_i == CSR_PMPADDR0 + 12'(n)) begin
        csr_rdata_o = addr_q[n];
      end
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

endmodule

// ==== src/pmp_range_decoder.sv ====
module pmp_range_decoder #(
  parameter bit FIRST = 1'b0                                   // entry 0 has no predecessor
) (
  input  logic [1:0]                      mode_i,              // A field
  input  logic [mem_access_pkg::XLEN-1:0] addr_i,              // own pmpaddr
  input  logic [mem_access_pkg::XLEN-1:0] prev_addr_i,         // pmpaddr of entry i-1
  output logic [mem_access_pkg::PLEN-3:0] lb_o,                // first word in range
  output logic [mem_access_pkg::PLEN-3:0] ub_o                 // first word past range
);

  import pmp_cfg_pkg::*;
  import mem_access_pkg::*;

  logic [PLEN-3:0] pmaddr;        // own address in words
  logic [PLEN-3:0] prev;          // TOR base in words
  int unsigned     ones;          // trailing ones of pmaddr
  logic [PLEN-3:0] napot_mask;
  logic [PLEN-3:0] napot_incr;

  assign pmaddr = addr_i[PLEN-3:0];
  assign prev   = FIRST ? '0 : prev_addr_i[PLEN-3:0];

  //////////////////////////////////////////////////
  // napot size
  //////////////////////////////////////////////////

  always_comb begin : count_ones
    logic run;
    ones = 0;
    run  = 1'b1;
    for (int b = 0; b < PLEN-2; b++) begin
      if (run && pmaddr[b]) begin
        ones = ones + 1;
      end else begin
        run = 1'b0;                 // first zero ends the run
      end
    end
  end

  // region spans 2^(ones+1) words
  assign napot_mask = {(PLEN-2){1'b1}} << (ones + 1);
  assign napot_incr = (PLEN-2)'(1) << (ones + 1);

  //////////////////////////////////////////////////
  // bounds by mode
  //////////////////////////////////////////////////

  always_comb begin
    case (mode_i)
      TOR: begin
        lb_o = prev;
        ub_o = pmaddr;              // exclusive bound
      end
      NA4: begin
        lb_o = pmaddr;
        ub_o = pmaddr + (PLEN-2)'(1);
      end
      NAPOT: begin
        lb_o = pmaddr & napot_mask;
        ub_o = (pmaddr + napot_incr) & napot_mask;
      end
      default: begin                // OFF gives an empty range
        lb_o = '0;
        ub_o = '0;
      end
    endcase
  end

endmodule

// ==== src/pmp_checker.sv ====
module pmp_checker (
  input  logic                                                       clk_i,
  input  logic                                                       reset_i,

  // configuration from the csr file
  input  logic [pmp_cfg_pkg::PMP_CNT-1:0][7:0]                       cfg_i,
  input  logic [pmp_cfg_pkg::PMP_CNT-1:0][mem_access_pkg::XLEN-1:0]  addr_i,

  // physical access
  input  logic                                                       req_i,
  input  logic                                                       instr_i,
  input  logic                                                       we_i,
  input  logic [2:0]                                                 size_i,
  input  logic [mem_access_pkg::PLEN-1:0]                            adr_i,
  input  logic [1:0]                                                 prv_i,

  // registered result
  output logic                                                       rsp_valid_o,
  output logic                                                       exception_o
);

  import pmp_cfg_pkg::*;
  import mem_access_pkg::*;

  logic [PLEN-1:0]                 access_last;   // address of last byte
  logic [PLEN-3:0]                 access_lb;     // first word touched
  logic [PLEN-3:0]                 access_ub;     // last word touched, inclusive
  logic [PMP_CNT-1:0][PLEN-3:0]    pmp_lb;
  logic [PMP_CNT-1:0][PLEN-3:0]    pmp_ub;
  logic [PMP_CNT-1:0]              match_any;
  logic [PMP_CNT-1:0]              match_all;
  logic [PMP_IDX_W-1:0]            hit_idx;
  logic [7:0]                      hit_cfg;
  logic                            is_read;
  logic                            is_write;
  logic                            is_fetch;
  logic                            perm_fail;
  logic                            exc_d;

  //////////////////////////////////////////////////
  // access bounds
  //////////////////////////////////////////////////

  assign access_last = adr_i + PLEN'(size2bytes(size_i)) - PLEN'(1);
  assign access_lb   = adr_i[PLEN-1:2];
  assign access_ub   = access_last[PLEN-1:2];

  //////////////////////////////////////////////////
  // per entry range match
  //////////////////////////////////////////////////

  // entry i sees entry i-1 as its TOR base
  for (genvar i = 0; i < PMP_CNT; i++) begin : gen_entry
    pmp_range_decoder #(
      .FIRST       (i == 0)
    ) u_range (
      .mode_i      (cfg_i[i][CFG_A_LO +: 2]),
      .addr_i      (addr_i[i]),
      .prev_addr_i (addr_i[(i == 0) ? 0 : i - 1]),   // ignored by entry 0
      .lb_o        (pmp_lb[i]),
      .ub_o        (pmp_ub[i])
    );

    // some byte inside and entry not OFF
    assign match_any[i] = !((access_lb >= pmp_ub[i]) || (access_ub < pmp_lb[i])) &&
                          (cfg_i[i][CFG_A_LO +: 2] != OFF);
    // every byte inside
    assign match_all[i] = (access_lb >= pmp_lb[i]) && (access_ub < pmp_ub[i]);
  end

  //////////////////////////////////////////////////
  // priority and permission
  //////////////////////////////////////////////////

  // lowest index wins, so scan downwards
  always_comb begin
    hit_idx = '0;
    for (int n = PMP_CNT-1; n >= 0; n--) begin
      if (match_any[n]) begin
        hit_idx = PMP_IDX_W'(n);
      end
    end
  end

  assign hit_cfg  = cfg_i[hit_idx];

  assign is_fetch = instr_i;
  assign is_read  = ~instr_i & ~we_i;
  assign is_write = ~instr_i & we_i;

  assign perm_fail = (is_read  & ~hit_cfg[CFG_R]) |
                     (is_write & ~hit_cfg[CFG_W]) |
                     (is_fetch & ~hit_cfg[CFG_X]);

  always_comb begin
    if (!(|match_any)) begin
      exc_d = (prv_i != PRV_M);                     // only M may run unmatched
    end else begin
      exc_d = ~match_all[hit_idx] |                 // partial cover faults always
              (((prv_i != PRV_M) | hit_cfg[CFG_L]) & perm_fail);
    end
  end

  //////////////////////////////////////////////////
  // response register
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
      exception_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
      exception_o <= req_i & exc_d;                 // flag only with a response
    end
  end

endmodule

// ==== src/pmp_unit.sv ====
module pmp_unit (
  input  logic                            clk_i,
  input  logic                            reset_i,

  // csr access
  input  logic                            csr_we_i,
  input  logic [11:0]                     csr_adr_i,
  input  logic [mem_access_pkg::XLEN-1:0] csr_wdata_i,
  output logic [mem_access_pkg::XLEN-1:0] csr_rdata_o,

  // physical access request
  input  logic                            req_i,
  input  logic                            instr_i,       // instruction fetch
  input  logic                            we_i,          // store
  input  logic [2:0]                      size_i,
  input  logic [mem_access_pkg::PLEN-1:0] adr_i,
  input  logic [1:0]                      prv_i,

  // response one cycle later
  output logic                            rsp_valid_o,
  output logic                            exception_o
);

  import pmp_cfg_pkg::*;
  import mem_access_pkg::*;

  logic [PMP_CNT-1:0][7:0]      cfg;      // pmpcfg bytes
  logic [PMP_CNT-1:0][XLEN-1:0] addr;     // pmpaddr registers

  //////////////////////////////////////////////////
  // configuration registers
  //////////////////////////////////////////////////

  pmp_csr_file u_csr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .csr_we_i    (csr_we_i),
    .csr_adr_i   (csr_adr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .cfg_o       (cfg),
    .addr_o      (addr)
  );

  //////////////////////////////////////////////////
  // access check
  //////////////////////////////////////////////////

  pmp_checker u_chk (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cfg_i       (cfg),
    .addr_i      (addr),
    .req_i       (req_i),
    .instr_i     (instr_i),
    .we_i        (we_i),
    .size_i      (size_i),
    .adr_i       (adr_i),
    .prv_i       (prv_i),
    .rsp_valid_o (rsp_valid_o),
    .exception_o (exception_o)
  );

endmodule

// ==== tests/pmp_unit_tb.sv ====
module pmp_unit_tb;

  import pmp_cfg_pkg::*;
  import mem_access_pkg::*;

  localparam int CYCLE_LIMIT = 3000;     // about four times the test length

  logic            clk_i;
  logic            reset_i;
  logic            csr_we_i;
  logic [11:0]     csr_adr_i;
  logic [XLEN-1:0] csr_wdata_i;
  logic [XLEN-1:0] csr_rdata_o;
  logic            req_i;
  logic            instr_i;
  logic            we_i;
  logic [2:0]      size_i;
  logic [PLEN-1:0] adr_i;
  logic [1:0]      prv_i;
  logic            rsp_valid_o;
  logic            exception_o;

  logic [7:0]      sh_cfg  [PMP_CNT];    // model copy of pmpcfg bytes
  logic [XLEN-1:0] sh_addr [PMP_CNT];    // model copy of pmpaddr
  bit              exp_q   [$];          // expected flags in flight
  string           name_q  [$];
  int              pending;
  int              errors;
  int              n_pass;
  int              n_fail;
  int              cycles;
  bit              got_exp;
  string           got_name;

  pmp_unit uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // response exactly one cycle after each request
  assert property (@(posedge clk_i) disable iff (reset_i) rsp_valid_o == $past(req_i))
    else begin
      $display("response strobe did not follow the request by one cycle");
      errors++;
    end

  assert property (@(posedge clk_i) disable iff (reset_i) exception_o |-> rsp_valid_o)
    else begin
      $display("exception raised without a response strobe");
      errors++;
    end

  always @(negedge clk_i) begin
    if (!reset_i && rsp_valid_o) begin
      if (pending == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else begin
        got_exp  = exp_q.pop_front();
        got_name = name_q.pop_front();
        pending--;
        assert (exception_o == got_exp)
          else begin
            $display("[FAIL] %s: expected %0d, actual %0d", got_name, got_exp, exception_o);
            errors++;
          end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic bit model_exc(bit instr, bit we, logic [2:0] size, logic [63:0] a,
                                   logic [1:0] prv);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] last;
    logic [63:0] word;
    logic [7:0]  c;
    int          t;
    bit          perm;
    last = a + (64'd1 << size);                        // exclusive end
    for (int i = 0; i < PMP_CNT; i++) begin
      c    = sh_cfg[i];
      word = {32'd0, sh_addr[i]};
      lo   = 64'd0;
      hi   = 64'd0;
      if (c[4:3] == TOR) begin
        lo = (i == 0) ? 64'd0 : {30'd0, sh_addr[i-1], 2'b00};
        hi = word << 2;
      end else if (c[4:3] == NA4) begin
        lo = word << 2;
        hi = lo + 64'd4;
      end else if (c[4:3] == NAPOT) begin
        t = 0;
        while (t < 32 && word[t]) t++;                 // trailing ones
        lo = (word & ~((64'd1 << (t + 1)) - 64'd1)) << 2;
        hi = lo + (64'd1 << (t + 3));
      end
      if (c[4:3] != OFF && a < hi && last > lo) begin
        perm = instr ? c[2] : (we ? c[1] : c[0]);
        return (a < lo || last > hi) || ((prv != PRV_M || c[7]) && !perm);
      end
    end
    return prv != PRV_M;                               // nothing matched
  endfunction

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  task automatic go_idle();
    @(negedge clk_i);
    req_i    = 1'b0;
    csr_we_i = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i = 1'b1;
    req_i   = 1'b0;
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    for (int i = 0; i < PMP_CNT; i++) begin
      sh_cfg[i]  = '0;
      sh_addr[i] = '0;
    end
  endtask

  task automatic csr_write(logic [11:0] adr, logic [XLEN-1:0] data);
    int         n;
    logic [7:0] b;
    @(negedge clk_i);
    req_i       = 1'b0;
    csr_we_i    = 1'b1;
    csr_adr_i   = adr;
    csr_wdata_i = data;
    if (adr == CSR_PMPCFG0 || adr == CSR_PMPCFG1) begin
      for (int j = 0; j < 4; j++) begin
        n = (adr - CSR_PMPCFG0) * 4 + j;
        if (!sh_cfg[n][7]) begin
          b       = data[8*j +: 8] & 8'h9f;
          b[1]    = b[1] & b[0];                       // W needs R
          sh_cfg[n] = b;
        end
      end
    end else if (adr >= CSR_PMPADDR0 && adr < CSR_PMPADDR0 + 12'(PMP_CNT)) begin
      n = adr - CSR_PMPADDR0;
      if (!sh_cfg[n][7]) begin
        if (n == PMP_CNT - 1) begin
          sh_addr[n] = data;
        end else if (!(sh_cfg[n+1][7] && sh_cfg[n+1][4:3] == TOR)) begin
          sh_addr[n] = data;
        end
      end
    end
  endtask

  task automatic csr_check(string name, logic [11:0] adr, logic [XLEN-1:0] exp);
    @(negedge clk_i);
    req_i     = 1'b0;
    csr_we_i  = 1'b0;
    csr_adr_i = adr;
    #5;
    assert (csr_rdata_o == exp)
      else begin
        $display("[FAIL] %s: expected %h, actual %h", name, exp, csr_rdata_o);
        errors++;
      end
  endtask

  task automatic issue(string name, bit instr, bit we, logic [2:0] size, logic [PLEN-1:0] a,
                       logic [1:0] prv, bit exp);
    @(negedge clk_i);
    csr_we_i = 1'b0;
    req_i    = 1'b1;
    instr_i  = instr;
    we_i     = we;
    size_i   = size;
    adr_i    = a;
    prv_i    = prv;
    exp_q.push_back(exp);
    name_q.push_back(name);
    pending++;
  endtask

  task automatic end_test(string name, int err_before);
    go_idle();
    wait (pending == 0);
    @(negedge clk_i);
    if (errors == err_before) begin
      $display("PASS %s", name);
      n_pass++;
    end else begin
      $display("FAIL %s", name);
      n_fail++;
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int          e0;
    logic [31:0] a;
    logic [31:0] rnd_adr;
    logic [1:0]  p;
    bit          ins;
    bit          wr;
    logic [2:0]  sz;
    void'($urandom(32'h9888));
    reset_i     = 1'b1;
    csr_we_i    = 1'b0;
    csr_adr_i   = '0;
    csr_wdata_i = '0;
    req_i       = 1'b0;
    instr_i     = 1'b0;
    we_i        = 1'b0;
    size_i      = '0;
    adr_i       = '0;
    prv_i       = PRV_M;
    errors      = 0;
    n_pass      = 0;
    n_fail      = 0;
    cycles      = 0;
    pending     = 0;
    apply_reset();

    e0 = errors;                                       // reset state
    csr_check("reset_cfg0", CSR_PMPCFG0, 0);
    csr_check("reset_cfg1", CSR_PMPCFG1, 0);
    for (int i = 0; i < PMP_CNT; i++) csr_check("reset_addr", CSR_PMPADDR0 + 12'(i), 0);
    issue("reset_m_read", 0, 0, WORD, 34'h100, PRV_M, 0);
    issue("reset_u_read", 0, 0, WORD, 34'h100, PRV_U, 1);
    issue("reset_u_write", 0, 1, WORD, 34'h100, PRV_U, 1);
    issue("reset_u_fetch", 1, 0, WORD, 34'h100, PRV_U, 1);
    end_test("reset", e0);

    e0 = errors;                                       // NA4 at 0x100 and 64 byte NAPOT at 0x200
    csr_write(CSR_PMPADDR0, 32'h40);
    csr_write(CSR_PMPADDR0 + 12'd1, 32'h87);
    csr_write(CSR_PMPCFG0, 32'h0000_1f11);
    issue("na4_read", 0, 0, WORD, 34'h100, PRV_U, 0);
    issue("na4_write", 0, 1, WORD, 34'h100, PRV_U, 1);
    issue("na4_fetch", 1, 0, WORD, 34'h100, PRV_U, 1);
    issue("na4_beyond", 0, 0, WORD, 34'h104, PRV_U, 1);
    issue("napot_low", 0, 0, WORD, 34'h200, PRV_U, 0);
    issue("napot_high", 0, 0, WORD, 34'h23c, PRV_U, 0);
    issue("napot_write", 0, 1, HWORD, 34'h220, PRV_U, 0);
    issue("napot_above", 0, 0, WORD, 34'h240, PRV_U, 1);
    issue("napot_below", 0, 0, WORD, 34'h1fc, PRV_U, 1);
    end_test("na4_napot", e0);

    e0 = errors;                                       // TOR 0x400..0x500 on entry 1
    csr_write(CSR_PMPADDR0, 32'h100);
    csr_write(CSR_PMPADDR0 + 12'd1, 32'h140);
    csr_write(CSR_PMPCFG0, 32'h0000_0f00);
    issue("tor_base", 0, 0, WORD, 34'h400, PRV_U, 0);
    issue("tor_top", 0, 0, WORD, 34'h4fc, PRV_U, 0);
    issue("tor_above", 0, 0, WORD, 34'h500, PRV_U, 1);
    issue("tor_below", 0, 0, WORD, 34'h3fc, PRV_U, 1);
    issue("tor_straddle_m", 0, 0, DWORD, 34'h4fc, PRV_M, 1);
    issue("tor_inside_m", 0, 0, DWORD, 34'h4f8, PRV_M, 0);
    issue("tor_unmatched_m", 0, 0, WORD, 34'h500, PRV_M, 0);
    end_test("tor", e0);

    e0 = errors;                                       // NA4 R-only over NAPOT RWX at 0x600
    csr_write(CSR_PMPADDR0 + 12'd2, 32'h180);
    csr_write(CSR_PMPADDR0 + 12'd3, 32'h187);
    csr_write(CSR_PMPCFG0, 32'h1f11_0f00);
    issue("prio_write_low", 0, 1, WORD, 34'h600, PRV_U, 1);
    issue("prio_write_next", 0, 1, WORD, 34'h604, PRV_U, 0);
    issue("prio_read_low", 0, 0, WORD, 34'h600, PRV_U, 0);
    end_test("priority", e0);

    e0 = errors;                                       // entry 4 locked TOR with R only
    csr_write(CSR_PMPADDR0 + 12'd4, 32'h200);
    csr_write(CSR_PMPCFG1, 32'h0000_0089);
    issue("lock_m_write", 0, 1, WORD, 34'h700, PRV_M, 1);
    issue("lock_m_read", 0, 0, WORD, 34'h700, PRV_M, 0);
    csr_write(CSR_PMPCFG1, 32'h0000_121f);
    csr_write(CSR_PMPADDR0 + 12'd4, 32'h300);
    csr_write(CSR_PMPADDR0 + 12'd3, 32'h123);
    csr_check("lock_cfg_and_reserved", CSR_PMPCFG1, 32'h0000_1089);
    csr_check("lock_own_addr", CSR_PMPADDR0 + 12'd4, 32'h200);
    csr_check("lock_prev_addr", CSR_PMPADDR0 + 12'd3, 32'h187);
    csr_write(12'h3a2, 32'h1f1f_1f1f);                 // unmapped csr
    csr_check("unknown_read", 12'h3a2, 0);
    csr_check("unknown_write", CSR_PMPCFG0, 32'h1f11_0f00);
    issue("lock_m_write_again", 0, 1, WORD, 34'h700, PRV_M, 1);
    end_test("lock", e0);

    apply_reset();
    e0 = errors;                                       // random back-to-back requests
    for (int blk = 0; blk < 30; blk++) begin
      csr_write(CSR_PMPCFG0, $urandom & 32'h1f1f_1f1f);
      csr_write(CSR_PMPCFG1, $urandom & 32'h1f1f_1f1f);
      a = $urandom % 16;
      for (int i = 0; i < PMP_CNT; i++) begin
        csr_write(CSR_PMPADDR0 + 12'(i), a);
        a = a + 1 + ($urandom % 16);                   // strictly rising bounds
      end
      for (int r = 0; r < 10; r++) begin
        rnd_adr = $urandom % 32'h400;
        sz      = 3'($urandom % 4);
        ins     = 1'($urandom);
        wr      = 1'($urandom);
        p       = 2'($urandom % 3);
        if (p == 2'd2) p = PRV_M;
        issue("random", ins, wr, sz, PLEN'(rnd_adr), p,
              model_exc(ins, wr, sz, {32'd0, rnd_adr}, p));
      end
    end
    end_test("random", e0);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             n_pass + n_fail, n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== pmp_unit.f ====
src/pmp_cfg_pkg.sv
src/mem_access_pkg.sv
src/pmp_csr_file.sv
src/pmp_range_decoder.sv
src/pmp_checker.sv
src/pmp_unit.sv
tests/pmp_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pmp_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module pmp_unit_tb -f pmp_unit.f \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vpmp_unit_tb)
echo "$out"
echo "$out" | grep -qx "all tests passed" && exit 0 || exit 1
